//--- hdl/upd_periph_pkg.sv
// Register map, interrupt source indices, vectors and reset values of the peripheral block
package upd_periph_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and dividers

  localparam int SPR_W      = 8;
  localparam int TM_W       = 12;
  localparam int PRESCALE_W = 3;
  localparam int NUM_INT    = 4;
  localparam int SAMPLE_DIV = 12;

  ////////////////////////////////////////////////////////////////////////////
  // Special register map indexed by AXI address bits [5:2]

  typedef enum logic [3:0] {
    PA  = 4'd0,
    PB  = 4'd1,
    PC  = 4'd2,
    MK  = 4'd3,
    MB  = 4'd4,
    MC  = 4'd5,
    TM0 = 4'd6,
    TM1 = 4'd7,
    IE  = 4'd8
  } spr_e;

  // Interrupt sources with index 0 at the highest priority
  typedef enum logic [1:0] {
    INT0 = 2'd0,
    INTT = 2'd1,
    INT1 = 2'd2,
    INT2 = 2'd3
  } int_src_e;

  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2
  } axi_resp_e;

  // Vector addresses per source
  localparam logic [7:0] VEC_INT0 = 8'h04;
  localparam logic [7:0] VEC_INTT = 8'h08;
  localparam logic [7:0] VEC_INT1 = 8'h10;
  localparam logic [7:0] VEC_INT2 = 8'h20;

  localparam logic [SPR_W-1:0] MK_RESET   = 8'hff;
  localparam logic [SPR_W-1:0] MODE_RESET = 8'hff;
  localparam logic [TM_W-1:0]  TM_RESET   = 12'hfff;

  // MK bit 5 set means INT2 is active high
  localparam int MK_INT2_POL = 5;

endpackage

//--- hdl/spr_bus_if.sv
// Interface for one special-register access between the bus slave and the register bank
`timescale 1ns/1ps

interface spr_bus_if;

  logic                                wr_en;
  logic                                rd_en;
  upd_periph_pkg::spr_e                sel;
  logic [upd_periph_pkg::SPR_W-1:0]    wdata;
  // Combinational read data for the current sel
  logic [upd_periph_pkg::SPR_W-1:0]    rdata;

  modport slave (
    output wr_en,
    output rd_en,
    output sel,
    output wdata,
    input  rdata
  );

  modport bank (
    input  wr_en,
    input  rd_en,
    input  sel,
    input  wdata,
    output rdata
  );

endinterface

//--- hdl/axil_spr_slave.sv
// AXI4-Lite slave that turns single bus transactions into special-register accesses
`timescale 1ns/1ps

module axil_spr_slave (
  input  logic        CLK,
  input  logic        rst,
  input  logic [5:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [5:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  spr_bus_if.slave    bus
);

  logic [3:0]                       wr_idx;
  logic [3:0]                       rd_idx;
  logic                             wr_mapped;
  logic                             rd_mapped;
  logic                             wr_go;
  logic                             rd_go;
  logic                             bvalid_q;
  logic                             rvalid_q;
  logic [1:0]                       bresp_q;
  logic [1:0]                       rresp_q;
  logic [upd_periph_pkg::SPR_W-1:0] rdata_q;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode and acceptance

  assign wr_idx    = awaddr[5:2];
  assign rd_idx    = araddr[5:2];
  // Indices above IE have no register behind them
  assign wr_mapped = (wr_idx <= 4'(upd_periph_pkg::IE));
  assign rd_mapped = (rd_idx <= 4'(upd_periph_pkg::IE));

  // Write wins when both arrive in the same cycle and the read waits one cycle
  assign wr_go = awvalid & wvalid & ~bvalid_q;
  assign rd_go = arvalid & ~rvalid_q & ~wr_go;

  assign awready = wr_go;
  assign wready  = wr_go;
  assign arready = rd_go;

  // Register access in the accepting cycle
  assign bus.wr_en = wr_go & wr_mapped & wstrb[0];
  assign bus.rd_en = rd_go & rd_mapped;
  assign bus.sel   = upd_periph_pkg::spr_e'(wr_go ? wr_idx : rd_idx);
  assign bus.wdata = wdata[upd_periph_pkg::SPR_W-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Write response

  always_ff @(posedge CLK) begin
    if (rst) begin
      bvalid_q <= 1'b0;
    end else if (wr_go) begin
      bvalid_q <= 1'b1;
    end else if (bready) begin
      bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (wr_go) begin
      bresp_q <= wr_mapped ? upd_periph_pkg::OKAY : upd_periph_pkg::SLVERR;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read response

  always_ff @(posedge CLK) begin
    if (rst) begin
      rvalid_q <= 1'b0;
    end else if (rd_go) begin
      rvalid_q <= 1'b1;
    end else if (rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // Unmapped reads return zero
  always_ff @(posedge CLK) begin
    if (bus.rd_en) begin
      rdata_q <= bus.rdata;
    end else if (rd_go) begin
      rdata_q <= '0;
    end
    if (rd_go) begin
      rresp_q <= rd_mapped ? upd_periph_pkg::OKAY : upd_periph_pkg::SLVERR;
    end
  end

  assign bvalid = bvalid_q;
  assign bresp  = bresp_q;
  assign rvalid = rvalid_q;
  assign rresp  = rresp_q;
  assign rdata  = {{(32 - upd_periph_pkg::SPR_W){1'b0}}, rdata_q};

endmodule

//--- hdl/port_mode_regs.sv
// Port, mode, mask, timer reload and IE registers with read multiplexer and port pin logic
`timescale 1ns/1ps

module port_mode_regs (
  input  logic                                CLK,
  input  logic                                rst,
  input  logic [upd_periph_pkg::SPR_W-1:0]    pb_i,
  input  logic [upd_periph_pkg::SPR_W-1:0]    pc_i,
  input  logic                                int_taken,
  spr_bus_if.bank                             bus,
  output logic [upd_periph_pkg::SPR_W-1:0]    pa_o,
  output logic [upd_periph_pkg::SPR_W-1:0]    pb_o,
  output logic [upd_periph_pkg::SPR_W-1:0]    pb_oe,
  output logic [upd_periph_pkg::SPR_W-1:0]    pc_o,
  output logic [upd_periph_pkg::SPR_W-1:0]    pc_oe,
  output logic [upd_periph_pkg::SPR_W-1:0]    mk,
  output logic                                ie,
  output logic [upd_periph_pkg::TM_W-1:0]     tm_reload
);

  logic [upd_periph_pkg::SPR_W-1:0] pa_q, pb_q, pc_q;
  logic [upd_periph_pkg::SPR_W-1:0] mb_q, mc_q, mk_q;
  logic [upd_periph_pkg::SPR_W-1:0] pb_rd, pc_rd;
  logic [upd_periph_pkg::TM_W-1:0]  tm_q;
  logic                             ie_q;

  always_ff @(posedge CLK) begin
    if (rst) begin
      pa_q <= '0;
      pb_q <= '0;
      pc_q <= '0;
      mb_q <= upd_periph_pkg::MODE_RESET;
      mc_q <= upd_periph_pkg::MODE_RESET;
      mk_q <= upd_periph_pkg::MK_RESET;
      tm_q <= upd_periph_pkg::TM_RESET;
    end else if (bus.wr_en) begin
      case (bus.sel)
        upd_periph_pkg::PA:  pa_q <= bus.wdata;
        upd_periph_pkg::PB:  pb_q <= bus.wdata;
        upd_periph_pkg::PC:  pc_q <= bus.wdata;
        upd_periph_pkg::MK:  mk_q <= bus.wdata;
        upd_periph_pkg::MB:  mb_q <= bus.wdata;
        upd_periph_pkg::MC:  mc_q <= bus.wdata;
        upd_periph_pkg::TM0: tm_q[7:0] <= bus.wdata;
        upd_periph_pkg::TM1: tm_q[11:8] <= bus.wdata[3:0];
        default: ;
      endcase
    end
  end

  // Taking an interrupt clears IE even against a write in the same cycle
  always_ff @(posedge CLK) begin
    if (rst) begin
      ie_q <= 1'b0;
    end else if (int_taken) begin
      ie_q <= 1'b0;
    end else if (bus.wr_en && bus.sel == upd_periph_pkg::IE) begin
      ie_q <= bus.wdata[0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pin logic where a mode bit of 0 makes the pin an output

  assign pb_oe = ~mb_q;
  assign pc_oe = {~mc_q[7], 5'b11110, ~mc_q[1:0]};

  // Output latch where driven and pin elsewhere
  assign pb_rd = (pb_i & ~pb_oe) | (pb_q & pb_oe);
  assign pc_rd = (pc_i & ~pc_oe) | (pc_q & pc_oe);

  always_comb begin
    case (bus.sel)
      upd_periph_pkg::PA:  bus.rdata = pa_q;
      upd_periph_pkg::PB:  bus.rdata = pb_rd;
      upd_periph_pkg::PC:  bus.rdata = pc_rd;
      upd_periph_pkg::MK:  bus.rdata = mk_q;
      upd_periph_pkg::MB:  bus.rdata = mb_q;
      upd_periph_pkg::MC:  bus.rdata = mc_q;
      upd_periph_pkg::TM0: bus.rdata = tm_q[7:0];
      upd_periph_pkg::TM1: bus.rdata = {4'b0000, tm_q[11:8]};
      upd_periph_pkg::IE:  bus.rdata = {7'b0000000, ie_q};
      default:             bus.rdata = '0;
    endcase
  end

  assign pa_o      = pa_q;
  assign pb_o      = pb_q;
  assign pc_o      = pc_q;
  assign mk        = mk_q;
  assign ie        = ie_q;
  assign tm_reload = tm_q;

endmodule

//--- hdl/interval_timer.sv
// Prescaled 12-bit interval timer that signals underflow
`timescale 1ns/1ps

module interval_timer (
  input  logic                              CLK,
  input  logic                              rst,
  input  logic [upd_periph_pkg::TM_W-1:0]   tm_reload,
  output logic                              underflow
);

  // Counter in the upper bits and /8 prescaler in the low bits
  logic [upd_periph_pkg::TM_W+upd_periph_pkg::PRESCALE_W-1:0] tc;
  logic                                                       tc_zero;

  assign tc_zero = (tc == '0);

  ////////////////////////////////////////////////////////////////////////////
  // Down counter
  //
  // Counts every cycle. At zero the counter takes the TM value and the
  // prescaler restarts at all ones, so one period is (TM+1)*8 cycles.

  always_ff @(posedge CLK) begin
    if (rst) begin
      tc <= '1;
    end else if (tc_zero) begin
      tc <= {tm_reload, {upd_periph_pkg::PRESCALE_W{1'b1}}};
    end else begin
      tc <= tc - 1'b1;
    end
  end

  // Single cycle since the reload leaves zero at once
  assign underflow = tc_zero;

endmodule

//--- hdl/int_sampler.sv
// First interrupt stage with /12 edge sampling and per-source set events
`timescale 1ns/1ps

module int_sampler (
  input  logic                                CLK,
  input  logic                                rst,
  input  logic                                int0,
  input  logic                                int1,
  input  logic                                int2,
  input  logic                                underflow,
  input  logic [upd_periph_pkg::SPR_W-1:0]    mk,
  output logic [upd_periph_pkg::NUM_INT-1:0]  set_req,
  output logic                                int0_level
);

  logic [3:0] div_cnt;
  logic       smp_en;
  logic [3:0] hist1;
  logic [3:0] hist2;
  logic       int2_act;

  // Sample enable every SAMPLE_DIV cycles
  assign smp_en = (div_cnt == 4'(upd_periph_pkg::SAMPLE_DIV - 1));

  always_ff @(posedge CLK) begin
    if (rst) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= smp_en ? 4'd0 : div_cnt + 4'd1;
    end
  end

  // INT2 is active low unless the MK polarity bit is set
  assign int2_act = int2 ^ ~mk[upd_periph_pkg::MK_INT2_POL];

  always_ff @(posedge CLK) begin
    if (rst) begin
      hist1 <= '0;
      hist2 <= '0;
    end else if (smp_en) begin
      hist1 <= {hist1[2:0], int1};
      hist2 <= {hist2[2:0], int2_act};
    end
  end

  // Edge seen as one idle sample followed by three active ones
  always_comb begin
    set_req = '0;
    set_req[upd_periph_pkg::INT0] = int0;
    set_req[upd_periph_pkg::INTT] = underflow;
    set_req[upd_periph_pkg::INT1] = smp_en & (hist1 == 4'b0111);
    set_req[upd_periph_pkg::INT2] = smp_en & (hist2 == 4'b0111);
  end

  assign int0_level = int0;

endmodule

//--- hdl/int_arbiter.sv
// Pending latch, masked snapshot, priority encoder and interrupt vector handshake
`timescale 1ns/1ps

module int_arbiter (
  input  logic                                CLK,
  input  logic                                rst,
  input  logic [upd_periph_pkg::NUM_INT-1:0]  set_req,
  input  logic                                int0_level,
  input  logic [upd_periph_pkg::SPR_W-1:0]    mk,
  input  logic                                ie,
  input  logic                                int_ready,
  output logic                                int_valid,
  output logic [7:0]                          int_vector,
  output logic                                int_taken
);

  logic [upd_periph_pkg::NUM_INT-1:0] pend;
  logic [upd_periph_pkg::NUM_INT-1:0] pend_clr;
  logic [upd_periph_pkg::NUM_INT-1:0] unmasked;
  logic [upd_periph_pkg::NUM_INT-1:0] snap;
  logic [upd_periph_pkg::NUM_INT-1:0] grant;
  logic                               valid_q;

  assign int_taken = valid_q & int_ready;

  // Lowest set index wins
  assign grant = snap & (~snap + 1'b1);

  ////////////////////////////////////////////////////////////////////////////
  // Pending latch

  always_comb begin
    pend_clr = int_taken ? grant : '0;
    // INT0 is level sensitive and drops with its input
    if (!int0_level) begin
      pend_clr[upd_periph_pkg::INT0] = 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      pend <= '0;
    end else begin
      pend <= (pend & ~pend_clr) | set_req;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Snapshot and handshake
  //
  // The snapshot is frozen from the first non-empty load until the
  // handshake, so the vector holds while int_valid is high.

  assign unmasked = {upd_periph_pkg::NUM_INT{ie}} & ~mk[upd_periph_pkg::NUM_INT-1:0];

  always_ff @(posedge CLK) begin
    if (rst) begin
      snap    <= '0;
      valid_q <= 1'b0;
    end else begin
      if (int_taken) begin
        snap <= '0;
      end else if (!valid_q && snap == '0) begin
        snap <= pend & unmasked;
      end
      valid_q <= (snap != '0) & ~int_taken;
    end
  end

  always_comb begin
    case (1'b1)
      grant[upd_periph_pkg::INT0]: int_vector = upd_periph_pkg::VEC_INT0;
      grant[upd_periph_pkg::INTT]: int_vector = upd_periph_pkg::VEC_INTT;
      grant[upd_periph_pkg::INT1]: int_vector = upd_periph_pkg::VEC_INT1;
      grant[upd_periph_pkg::INT2]: int_vector = upd_periph_pkg::VEC_INT2;
      default:                     int_vector = 8'h00;
    endcase
  end

  assign int_valid = valid_q;

endmodule

//--- hdl/upd_periph_top.sv
// Top level of the peripheral block with bus slave, registers, timer and interrupt stages
`timescale 1ns/1ps

module upd_periph_top (
  input  logic        CLK,
  input  logic        rst,
  // AXI4-Lite slave
  input  logic [5:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [5:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  // Ports
  output logic [7:0]  pa_o,
  input  logic [7:0]  pb_i,
  output logic [7:0]  pb_o,
  output logic [7:0]  pb_oe,
  input  logic [7:0]  pc_i,
  output logic [7:0]  pc_o,
  output logic [7:0]  pc_oe,
  // Interrupt inputs and vector handshake
  input  logic        int0,
  input  logic        int1,
  input  logic        int2,
  output logic        int_valid,
  output logic [7:0]  int_vector,
  input  logic        int_ready
);

  logic [upd_periph_pkg::NUM_INT-1:0] set_req;
  logic                               int0_level;
  logic                               underflow;
  logic [upd_periph_pkg::SPR_W-1:0]   mk;
  logic                               ie;
  logic [upd_periph_pkg::TM_W-1:0]    tm_reload;
  logic                               int_taken;

  spr_bus_if spr_bus ();

  axil_spr_slave u_slave (
    .CLK, .rst,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .bus (spr_bus.slave)
  );

  port_mode_regs u_regs (
    .CLK, .rst, .pb_i, .pc_i, .int_taken,
    .bus (spr_bus.bank),
    .pa_o, .pb_o, .pb_oe, .pc_o, .pc_oe, .mk, .ie, .tm_reload
  );

  interval_timer u_timer (
    .CLK, .rst, .tm_reload, .underflow
  );

  // Interrupt path from the sampler to the pending latch and arbiter
  int_sampler u_sampler (
    .CLK, .rst, .int0, .int1, .int2, .underflow, .mk, .set_req, .int0_level
  );

  int_arbiter u_arbiter (
    .CLK, .rst, .set_req, .int0_level, .mk, .ie, .int_ready,
    .int_valid, .int_vector, .int_taken
  );

endmodule

//--- verification/upd_periph_tb.sv
// Testbench for the peripheral block with register, pin and interrupt model, checks and watchdog
`timescale 1ns/1ps

module upd_periph_tb;

  localparam int SMP = upd_periph_pkg::SAMPLE_DIV;
  // First underflow comes after the full 15-bit count from reset
  localparam int TIMER_RESET_CYCLES = 1 << (upd_periph_pkg::TM_W + upd_periph_pkg::PRESCALE_W);
  // One run from reset to underflow plus the register and interrupt tests with margin
  localparam int WATCHDOG_CYCLES = 60000;

  logic        CLK;
  logic        rst;
  logic [5:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [5:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic [7:0]  pa_o, pb_i, pb_o, pb_oe, pc_i, pc_o, pc_oe;
  logic        int0, int1, int2;
  logic        int_valid;
  logic [7:0]  int_vector;
  logic        int_ready;

  // Register model
  logic [7:0]  m_pa, m_pb, m_pc, m_mk, m_mb, m_mc;
  logic [11:0] m_tm;
  logic        m_ie;
  int          err_value;
  int          err_other;

  upd_periph_top upd_periph_top_inst (.*);

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
    $display("tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Model of registers and pins

  function automatic void model_reset();
    m_pa = 8'h00;
    m_pb = 8'h00;
    m_pc = 8'h00;
    m_mk = 8'hff;
    m_mb = 8'hff;
    m_mc = 8'hff;
    m_tm = 12'hfff;
    m_ie = 1'b0;
  endfunction

  // Mode bit 0 drives the pin
  function automatic logic [7:0] exp_pb_oe();
    return ~m_mb;
  endfunction

  function automatic logic [7:0] exp_pc_oe();
    return {~m_mc[7], 5'b11110, ~m_mc[1:0]};
  endfunction

  function automatic void model_write(input logic [3:0] idx, input logic [7:0] val);
    case (idx)
      upd_periph_pkg::PA:  m_pa = val;
      upd_periph_pkg::PB:  m_pb = val;
      upd_periph_pkg::PC:  m_pc = val;
      upd_periph_pkg::MK:  m_mk = val;
      upd_periph_pkg::MB:  m_mb = val;
      upd_periph_pkg::MC:  m_mc = val;
      upd_periph_pkg::TM0: m_tm[7:0] = val;
      upd_periph_pkg::TM1: m_tm[11:8] = val[3:0];
      upd_periph_pkg::IE:  m_ie = val[0];
      default: ;
    endcase
  endfunction

  function automatic logic [7:0] model_read(input logic [3:0] idx);
    case (idx)
      upd_periph_pkg::PA:  return m_pa;
      upd_periph_pkg::PB:  return (m_pb & exp_pb_oe()) | (pb_i & ~exp_pb_oe());
      upd_periph_pkg::PC:  return (m_pc & exp_pc_oe()) | (pc_i & ~exp_pc_oe());
      upd_periph_pkg::MK:  return m_mk;
      upd_periph_pkg::MB:  return m_mb;
      upd_periph_pkg::MC:  return m_mc;
      upd_periph_pkg::TM0: return m_tm[7:0];
      upd_periph_pkg::TM1: return {4'h0, m_tm[11:8]};
      upd_periph_pkg::IE:  return {7'h00, m_ie};
      default:             return 8'h00;
    endcase
  endfunction

  function automatic logic [3:0] write_target(input int k);
    case (k)
      0:       return upd_periph_pkg::PA;
      1:       return upd_periph_pkg::MK;
      2:       return upd_periph_pkg::MB;
      3:       return upd_periph_pkg::MC;
      4:       return upd_periph_pkg::TM0;
      5:       return upd_periph_pkg::TM1;
      default: return upd_periph_pkg::IE;
    endcase
  endfunction

  task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_value++;
      $display("error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus and interrupt handshakes

  task automatic apply_reset();
    rst <= 1'b1;
    repeat (4) @(posedge CLK);
    rst <= 1'b0;
    model_reset();
  endtask

  task automatic axi_write(input logic [3:0] idx, input logic [7:0] val,
                           output logic [1:0] resp);
    int delay;
    @(posedge CLK);
    awaddr  <= {idx, 2'b00};
    wdata   <= {24'h000000, val};
    wstrb   <= 4'h1;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    @(negedge CLK);
    while (!(awready && wready)) @(negedge CLK);
    @(posedge CLK);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(negedge CLK);
    while (!bvalid) @(negedge CLK);
    resp  = bresp;
    delay = $urandom_range(3, 0);
    repeat (delay) @(posedge CLK);
    @(posedge CLK);
    bready <= 1'b1;
    @(posedge CLK);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] idx, output logic [31:0] data,
                          output logic [1:0] resp);
    int delay;
    @(posedge CLK);
    araddr  <= {idx, 2'b00};
    arvalid <= 1'b1;
    @(negedge CLK);
    while (!arready) @(negedge CLK);
    @(posedge CLK);
    arvalid <= 1'b0;
    @(negedge CLK);
    while (!rvalid) @(negedge CLK);
    data  = rdata;
    resp  = rresp;
    delay = $urandom_range(3, 0);
    repeat (delay) @(posedge CLK);
    @(posedge CLK);
    rready <= 1'b1;
    @(posedge CLK);
    rready <= 1'b0;
  endtask

  task automatic write_reg(input logic [3:0] idx, input logic [7:0] val);
    logic [1:0] resp;
    axi_write(idx, val, resp);
    model_write(idx, val);
    check_hex("bresp", 32'(resp), 32'(upd_periph_pkg::OKAY));
  endtask

  task automatic read_check(input logic [3:0] idx);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(idx, data, resp);
    check_hex($sformatf("rdata of register %0d", idx), data, 32'(model_read(idx)));
    check_hex("rresp", 32'(resp), 32'(upd_periph_pkg::OKAY));
  endtask

  // Waits for a request, checks its vector and accepts it
  task automatic take_int(input logic [7:0] vec, input int limit);
    int n;
    n = 0;
    @(negedge CLK);
    while (!int_valid && n < limit) begin
      @(negedge CLK);
      n++;
    end
    if (!int_valid) begin
      err_other++;
      $display("int_valid did not rise within %0d cycles, vector %h expected", limit, vec);
    end else begin
      check_hex("int_vector", 32'(int_vector), 32'(vec));
      @(posedge CLK);
      int_ready <= 1'b1;
      @(posedge CLK);
      int_ready <= 1'b0;
      m_ie = 1'b0;
    end
  endtask

  task automatic stay_quiet(input int cycles, input string what);
    bit seen;
    seen = 1'b0;
    repeat (cycles) begin
      @(negedge CLK);
      if (int_valid && !seen) begin
        seen = 1'b1;
        err_other++;
        $display("int_valid rose %s", what);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    logic [1:0]  resp;
    logic [31:0] data;
    logic [3:0]  idx;
    void'($urandom(65));
    rst       <= 1'b1;
    awaddr    <= '0;
    awvalid   <= 1'b0;
    wdata     <= '0;
    wstrb     <= '0;
    wvalid    <= 1'b0;
    bready    <= 1'b0;
    araddr    <= '0;
    arvalid   <= 1'b0;
    rready    <= 1'b0;
    pb_i      <= '0;
    pc_i      <= '0;
    int0      <= 1'b0;
    int1      <= 1'b0;
    int2      <= 1'b1;
    int_ready <= 1'b0;
    err_value = 0;
    err_other = 0;
    apply_reset();

    // Register read back
    repeat (24) begin
      idx = write_target($urandom_range(6, 0));
      write_reg(idx, 8'($urandom()));
      read_check(idx);
      check_hex("pa_o", 32'(pa_o), 32'(m_pa));
    end

    // Port mixing of latch and pins
    repeat (8) begin
      write_reg(upd_periph_pkg::MB, 8'($urandom()));
      write_reg(upd_periph_pkg::MC, 8'($urandom()));
      write_reg(upd_periph_pkg::PB, 8'($urandom()));
      write_reg(upd_periph_pkg::PC, 8'($urandom()));
      @(posedge CLK);
      pb_i <= 8'($urandom());
      pc_i <= 8'($urandom());
      read_check(upd_periph_pkg::PB);
      read_check(upd_periph_pkg::PC);
      check_hex("pb_oe", 32'(pb_oe), 32'(exp_pb_oe()));
      check_hex("pc_oe", 32'(pc_oe), 32'(exp_pc_oe()));
      check_hex("pb_o", 32'(pb_o), 32'(m_pb));
      check_hex("pc_o", 32'(pc_o), 32'(m_pc));
    end

    // Unmapped indices
    for (int i = 9; i < 16; i++) begin
      axi_write(4'(i), 8'($urandom()), resp);
      check_hex("bresp", 32'(resp), 32'(upd_periph_pkg::SLVERR));
      axi_read(4'(i), data, resp);
      check_hex("rresp", 32'(resp), 32'(upd_periph_pkg::SLVERR));
      check_hex("rdata", data, 32'h0);
    end
    for (int i = 0; i < 9; i++) begin
      read_check(4'(i));
    end

    // Timer interrupt with only INTT unmasked
    apply_reset();
    write_reg(upd_periph_pkg::TM0, 8'h03);
    write_reg(upd_periph_pkg::TM1, 8'h00);
    write_reg(upd_periph_pkg::MK, 8'hfd);
    write_reg(upd_periph_pkg::IE, 8'h01);
    take_int(8'h08, TIMER_RESET_CYCLES + 1000);
    read_check(upd_periph_pkg::IE);
    stay_quiet(200, "while IE was cleared by the taken interrupt");
    write_reg(upd_periph_pkg::IE, 8'h01);
    take_int(8'h08, 100);

    // INT1 rising edge and then INT2 with MK bit 5 set
    @(posedge CLK);
    int2 <= 1'b0;
    apply_reset();
    write_reg(upd_periph_pkg::MK, 8'hfb);
    write_reg(upd_periph_pkg::IE, 8'h01);
    repeat (5 * SMP) @(posedge CLK);
    int1 <= 1'b1;
    take_int(8'h10, 8 * SMP);
    @(posedge CLK);
    int1 <= 1'b0;
    write_reg(upd_periph_pkg::MK, 8'hf7);
    write_reg(upd_periph_pkg::IE, 8'h01);
    @(posedge CLK);
    int2 <= 1'b1;
    take_int(8'h20, 8 * SMP);
    write_reg(upd_periph_pkg::IE, 8'h01);
    stay_quiet(6 * SMP, "with INT2 held at its idle level");
    // Active-low pulse with the edge seen at its trailing end
    @(posedge CLK);
    int2 <= 1'b0;
    repeat (2 * SMP) @(posedge CLK);
    int2 <= 1'b1;
    take_int(8'h20, 8 * SMP);

    // INT0 and INT1 pending together and then a masked INT0
    write_reg(upd_periph_pkg::MK, 8'hfa);
    @(posedge CLK);
    int0 <= 1'b1;
    int1 <= 1'b1;
    stay_quiet(6 * SMP, "with IE cleared and two sources pending");
    write_reg(upd_periph_pkg::IE, 8'h01);
    take_int(8'h04, 20);
    @(posedge CLK);
    int0 <= 1'b0;
    repeat (4) @(posedge CLK);
    write_reg(upd_periph_pkg::IE, 8'h01);
    take_int(8'h10, 20);
    @(posedge CLK);
    int1 <= 1'b0;
    write_reg(upd_periph_pkg::MK, 8'hf3);
    write_reg(upd_periph_pkg::IE, 8'h01);
    @(posedge CLK);
    int0 <= 1'b1;
    stay_quiet(10 * SMP, "for INT0 with its mask bit set");
    @(posedge CLK);
    int0 <= 1'b0;

    $display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
    if (err_value == 0 && err_other == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- files.f
hdl/upd_periph_pkg.sv
hdl/spr_bus_if.sv
hdl/axil_spr_slave.sv
hdl/port_mode_regs.sv
hdl/interval_timer.sv
hdl/int_sampler.sv
hdl/int_arbiter.sv
hdl/upd_periph_top.sv
verification/upd_periph_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the pass line appears
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module upd_periph_tb -f files.f -o upd_periph_sim

output=$(./obj_dir/upd_periph_sim)
echo "$output"

echo "$output" | grep -qx "all tests passed"
